/* design/charBusIf.sv */
`timescale 1ns/10ps
`include "video_consts.svh"

interface charBusIf;

	logic                charEn;   // one strobe per character period
	logic                disEn;
	logic                cursor;
	logic                rowBit3;  // scan row bit 3, blanks the gap rows
	logic [`FSADR_W-1:0] fsAdr;
	logic [`ROW_W-1:0]   rowAdr;

	modport timing (
		input  charEn,
		output disEn, cursor, rowBit3, fsAdr, rowAdr
	);

	modport latch (
		input charEn, disEn, cursor, rowBit3, fsAdr, rowAdr
	);

	modport ula (
		output charEn
	);

endinterface

/* design/charLatch.sv */
`timescale 1ns/10ps
`include "video_consts.svh"

module charLatch (
	input  logic               CLK,
	input  logic               nRESET,
	input  logic [`DATA_W-1:0] vData,
	charBusIf.latch            bus,
	input  ulaPkg::ulaCtrl_t   ctrl,
	output logic [`DATA_W-1:0] latData,
	output logic               latDisEn,
	output logic               latCursorDraw
);

	logic [2:0] cursorSeg;  // one-hot, characters since the cursor
	logic       segDraw;

	// byte for the address the timing generator held last character
	always_ff @(posedge CLK) begin
		if (bus.charEn) begin
			latData <= vData;
		end
	end

	assign segDraw = (cursorSeg[0] & ctrl.cursorSeg1)
		| ((cursorSeg[1] | cursorSeg[2]) & ctrl.cursorSeg23);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			latDisEn      <= 1'b0;
			cursorSeg     <= '0;
			latCursorDraw <= 1'b0;
		end else if (bus.charEn) begin
			latDisEn <= bus.disEn & ~bus.rowBit3;  // rows 8 and up are gap lines
			if (bus.cursor) begin
				cursorSeg <= 3'b001;
			end else begin
				cursorSeg <= cursorSeg << 1;
			end
			// draw state travels with the byte it belongs to
			latCursorDraw <= (bus.cursor & ctrl.cursorWide) | segDraw;
		end
	end

endmodule

/* design/clockEnables.sv */
`timescale 1ns/10ps
`include "video_consts.svh"

module clockEnables (
	input  logic CLK,
	input  logic nRESET,
	output logic clk16En,
	output logic clk8En,
	output logic clk4En,
	output logic clk2En,
	output logic clk1En,
	output logic clk2vEn
);

	logic [$clog2(`DIV_LEN)-1:0] divCount;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + 1'b1;  // wraps every DIV_LEN clocks
		end
	end

	assign clk16En = 1'b1;
	assign clk8En  = ~divCount[0];
	assign clk4En  = divCount[1:0] == 2'd0;
	assign clk2En  = divCount[2:0] == 3'd0;
	assign clk1En  = divCount == '0;
	assign clk2vEn = divCount[2:0] == 3'd0;  // counts 0 and 8

endmodule

/* design/crtcPkg.sv */
`include "video_consts.svh"

package crtcPkg;

	// register numbers as the 6845 has them, the gaps are not implemented
	typedef enum logic [$clog2(`CRTC_REGS)-1:0] {
		regHTotal    = 4'd0,
		regHDisp     = 4'd1,
		regHSyncPos  = 4'd2,
		regSyncWidth = 4'd3,
		regVTotal    = 4'd4,
		regVDisp     = 4'd6,
		regVSyncPos  = 4'd7,
		regMaxScan   = 4'd9,
		regStartHi   = 4'd12,
		regStartLo   = 4'd13,
		regCursorHi  = 4'd14,
		regCursorLo  = 4'd15
	} crtcReg_t;

	typedef struct packed {
		logic [`COL_W-1:0]   hTotal;     // characters per line minus one
		logic [`COL_W-1:0]   hDisp;      // displayed characters per line
		logic [`COL_W-1:0]   hSyncPos;
		logic [7:0]          syncWidth;  // vsync lines high nibble, hsync chars low
		logic [`CROW_W-1:0]  vTotal;     // character rows minus one
		logic [`CROW_W-1:0]  vDisp;
		logic [`CROW_W-1:0]  vSyncPos;
		logic [`ROW_W-1:0]   maxScan;    // scan lines per row minus one
		logic [`FSADR_W-1:0] startAdr;
		logic [`FSADR_W-1:0] cursorAdr;
	} crtcRegs_t;

endpackage

/* design/crtcTiming.sv */
`timescale 1ns/10ps
`include "video_consts.svh"

module crtcTiming (
	input  logic               CLK,
	input  logic               nRESET,
	input  logic               procEn,
	input  logic               nCsCrtc,
	input  logic               a0,
	input  logic               rnw,
	input  logic [`DATA_W-1:0] pData,
	output logic               hsync,
	output logic               vsync,
	charBusIf.timing           bus
);

	logic [$clog2(`CRTC_REGS)-1:0] regIdx;
	crtcPkg::crtcRegs_t            regs;

	logic [`COL_W-1:0]   hCount;
	logic [`ROW_W-1:0]   rowCount;
	logic [`CROW_W-1:0]  vCount;
	logic [3:0]          vSyncLeft;  // vsync lines still to go

	logic                regWrite;
	logic                lineEnd;
	logic                lastScan;
	logic [`CROW_W-1:0]  nextV;
	logic [`COL_W-1:0]   hSyncOfs;
	logic [`FSADR_W-1:0] rowBase;

	assign regWrite = procEn & ~nCsCrtc & ~rnw;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			regIdx <= '0;
			regs   <= '0;
		end else if (regWrite) begin
			if (!a0) begin
				regIdx <= pData[$clog2(`CRTC_REGS)-1:0];
			end else begin
				case (regIdx)
					crtcPkg::regHTotal:    regs.hTotal    <= pData;
					crtcPkg::regHDisp:     regs.hDisp     <= pData;
					crtcPkg::regHSyncPos:  regs.hSyncPos  <= pData;
					crtcPkg::regSyncWidth: regs.syncWidth <= pData;
					crtcPkg::regVTotal:    regs.vTotal    <= pData[`CROW_W-1:0];
					crtcPkg::regVDisp:     regs.vDisp     <= pData[`CROW_W-1:0];
					crtcPkg::regVSyncPos:  regs.vSyncPos  <= pData[`CROW_W-1:0];
					crtcPkg::regMaxScan:   regs.maxScan   <= pData[`ROW_W-1:0];
					crtcPkg::regStartHi:   regs.startAdr[`FSADR_W-1:8]  <= pData[`FSADR_W-9:0];
					crtcPkg::regStartLo:   regs.startAdr[7:0]           <= pData;
					crtcPkg::regCursorHi:  regs.cursorAdr[`FSADR_W-1:8] <= pData[`FSADR_W-9:0];
					crtcPkg::regCursorLo:  regs.cursorAdr[7:0]          <= pData;
					default: ;  // unimplemented registers
				endcase
			end
		end
	end

	// >= so a smaller total written mid-line still wraps
	assign lineEnd  = hCount >= regs.hTotal;
	assign lastScan = rowCount >= regs.maxScan;

	always_comb begin
		if (!lastScan) begin
			nextV = vCount;
		end else if (vCount >= regs.vTotal) begin
			nextV = '0;
		end else begin
			nextV = vCount + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			hCount    <= '0;
			rowCount  <= '0;
			vCount    <= '0;
			vSyncLeft <= '0;
		end else if (bus.charEn) begin
			if (lineEnd) begin
				hCount   <= '0;
				rowCount <= lastScan ? '0 : rowCount + 1'b1;
				vCount   <= nextV;
				// vsync starts with the first scan line of its row
				if (lastScan && nextV == regs.vSyncPos) begin
					vSyncLeft <= regs.syncWidth[7:4];
				end else if (vSyncLeft != 4'd0) begin
					vSyncLeft <= vSyncLeft - 1'b1;
				end
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	assign hSyncOfs = hCount - regs.hSyncPos;
	assign hsync    = (hCount >= regs.hSyncPos) && (hSyncOfs < `COL_W'(regs.syncWidth[3:0]));
	assign vsync    = vSyncLeft != 4'd0;

	assign rowBase     = `FSADR_W'(vCount) * `FSADR_W'(regs.hDisp);
	assign bus.fsAdr   = regs.startAdr + rowBase + `FSADR_W'(hCount);
	assign bus.rowAdr  = rowCount;
	assign bus.rowBit3 = rowCount[3];
	assign bus.disEn   = (hCount < regs.hDisp) && (vCount < regs.vDisp);
	assign bus.cursor  = bus.disEn && (bus.fsAdr == regs.cursorAdr);

	// column stays within the programmed total
	assert property (@(posedge CLK) disable iff (!nRESET)
		hCount <= regs.hTotal);

endmodule

/* design/displayControl.sv */
`timescale 1ns/10ps
`include "video_consts.svh"

module displayControl (
	input  logic                CLK,
	input  logic                nRESET,
	input  logic                procEn,
	input  logic                nCsCrtc,
	input  logic                nCsUla,
	input  logic                rnw,
	input  logic                a0,
	input  logic [`DATA_W-1:0]  pData,
	input  logic [`DATA_W-1:0]  vData,
	output logic                hsync,
	output logic                vsync,
	output logic                txtMode,
	output logic [2:0]          rgb,
	output logic [`FSADR_W-1:0] frameStoreAdr,
	output logic [`ROW_W-1:0]   rowAddress
);

	charBusIf bus ();

	logic clk16En, clk8En, clk4En, clk2En, clk1En, clk2vEn;

	ulaPkg::ulaCtrl_t   ctrl;
	logic [`DATA_W-1:0] latData;
	logic               latDisEn;
	logic               latCursorDraw;

	clockEnables clkEn (.CLK, .nRESET, .clk16En, .clk8En, .clk4En, .clk2En, .clk1En, .clk2vEn);

	crtcTiming crtc (.CLK, .nRESET, .procEn, .nCsCrtc, .a0, .rnw, .pData, .hsync, .vsync,
		.bus(bus.timing));

	charLatch latch (.CLK, .nRESET, .vData, .bus(bus.latch), .ctrl, .latData, .latDisEn,
		.latCursorDraw);

	videoUla ula (.CLK, .nRESET, .procEn, .nCsUla, .a0, .rnw, .pData,
		.clk16En, .clk8En, .clk4En, .clk2En, .clk1En, .clk2vEn,
		.latData, .latDisEn, .latCursorDraw, .bus(bus.ula), .ctrl, .txtMode, .rgb);

	assign frameStoreAdr = bus.fsAdr;
	assign rowAddress    = bus.rowAdr;

	// address decode outside never selects both chips on one write
	assert property (@(posedge CLK) disable iff (!nRESET)
		(procEn && !rnw) |-> (nCsCrtc || nCsUla));

endmodule

/* design/ulaPkg.sv */
package ulaPkg;

	// pixels shifted out per 16 master clocks
	typedef enum logic [1:0] {
		rate2  = 2'd0,
		rate4  = 2'd1,
		rate8  = 2'd2,
		rate16 = 2'd3
	} pixRate_t;

	typedef struct packed {
		logic     cursorWide;   // cursor on the first character
		logic     cursorSeg1;   // and on the second
		logic     cursorSeg23;  // and on the third and fourth
		logic     fastChar;     // 8-clock characters when set
		pixRate_t pixRate;
		logic     txtMode;
		logic     flashOn;
	} ulaCtrl_t;

	typedef logic [2:0] rgb_t;

	// flash bit on top of the stored colour
	typedef struct packed {
		logic flash;
		rgb_t colour;
	} palEntry_t;

endpackage

/* design/videoUla.sv */
`timescale 1ns/10ps
`include "video_consts.svh"

module videoUla (
	input  logic               CLK,
	input  logic               nRESET,
	input  logic               procEn,
	input  logic               nCsUla,
	input  logic               a0,
	input  logic               rnw,
	input  logic [`DATA_W-1:0] pData,
	input  logic               clk16En,
	input  logic               clk8En,
	input  logic               clk4En,
	input  logic               clk2En,
	input  logic               clk1En,
	input  logic               clk2vEn,
	input  logic [`DATA_W-1:0] latData,
	input  logic               latDisEn,
	input  logic               latCursorDraw,
	charBusIf.ula              bus,
	output ulaPkg::ulaCtrl_t   ctrl,
	output logic               txtMode,
	output ulaPkg::rgb_t       rgb
);

	ulaPkg::palEntry_t palette [`PAL_ENTRIES];

	logic [`DATA_W-1:0]             shifter;
	logic                           pixDisEn;   // display enable of the byte in the shifter
	logic                           pixCursor;
	logic                           ulaWrite;
	logic                           shiftEn;
	logic [$clog2(`PAL_ENTRIES)-1:0] palIdx;
	ulaPkg::palEntry_t              entry;
	ulaPkg::rgb_t                   colour;
	ulaPkg::rgb_t                   shown;

	assign ulaWrite = procEn & ~nCsUla & ~rnw;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			ctrl <= '0;
		end else if (ulaWrite && !a0) begin
			ctrl <= ulaPkg::ulaCtrl_t'(pData);
		end
	end

	// high nibble picks the entry, low nibble is flash bit and colour
	always_ff @(posedge CLK) begin
		if (ulaWrite && a0) begin
			palette[pData[7:4]] <= ulaPkg::palEntry_t'(pData[3:0]);
		end
	end

	assign bus.charEn = ctrl.fastChar ? clk2vEn : clk1En;
	assign txtMode    = ctrl.txtMode;

	always_comb begin
		unique case (ctrl.pixRate)
			ulaPkg::rate2:  shiftEn = clk2En;
			ulaPkg::rate4:  shiftEn = clk4En;
			ulaPkg::rate8:  shiftEn = clk8En;
			ulaPkg::rate16: shiftEn = clk16En;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (bus.charEn) begin
			shifter <= latData;
		end else if (shiftEn) begin
			shifter <= {shifter[`DATA_W-2:0], 1'b1};
		end
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			pixDisEn  <= 1'b0;
			pixCursor <= 1'b0;
		end else if (bus.charEn) begin
			pixDisEn  <= latDisEn;
			pixCursor <= latCursorDraw;
		end
	end

	assign palIdx = {shifter[7], shifter[5], shifter[3], shifter[1]};
	assign entry  = palette[palIdx];

	// stored colours are inverted unless flashing shows them as written
	assign colour = (entry.flash & ctrl.flashOn) ? entry.colour : ~entry.colour;
	assign shown  = pixDisEn ? colour : 3'b000;
	assign rgb    = pixCursor ? ~shown : shown;

endmodule

/* include/video_consts.svh */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// framestore address and scan row widths
`define FSADR_W     14
`define ROW_W       5

// character column and character row counters
`define COL_W       8
`define CROW_W      7

// processor and video data bytes
`define DATA_W      8

// crtc register file size, reached through a 4-bit index
`define CRTC_REGS   16

// ula palette size
`define PAL_ENTRIES 16

// master clocks per slow character
`define DIV_LEN     16

`endif

/* run.sh */
#!/bin/sh
# build and run the display controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module displayControlTb -o simv

# the testbench prints its own verdict, the log search decides the exit status
./obj_dir/simv | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

/* sim.f */
+incdir+include
design/crtcPkg.sv
design/ulaPkg.sv
design/charBusIf.sv
design/clockEnables.sv
design/crtcTiming.sv
design/charLatch.sv
design/videoUla.sv
design/displayControl.sv
testbench/displayControlTb.sv

/* testbench/displayControlTb.sv */
`timescale 1ns/10ps
`include "video_consts.svh"

module displayControlTb;

	logic CLK, nRESET, procEn, nCsCrtc, nCsUla, rnw, a0;
	logic [`DATA_W-1:0] pData, vData;
	logic hsync, vsync, txtMode;
	ulaPkg::rgb_t rgb;
	logic [`FSADR_W-1:0] frameStoreAdr;
	logic [`ROW_W-1:0] rowAddress;

	displayControl uut (.CLK, .nRESET, .procEn, .nCsCrtc, .nCsUla, .rnw, .a0, .pData, .vData,
		.hsync, .vsync, .txtMode, .rgb, .frameStoreAdr, .rowAddress);

	// model of the registers and pipeline, stepped once per clock
	crtcPkg::crtcRegs_t mRegs;
	ulaPkg::ulaCtrl_t mCtrl;
	ulaPkg::palEntry_t mPal [`PAL_ENTRIES];
	logic [3:0] mIdx, mDiv, mVLeft, mSeg;
	logic [`COL_W-1:0] mH;
	logic [`ROW_W-1:0] mRow;
	logic [`CROW_W-1:0] mV;
	logic [7:0] mLatData, mShift;
	logic mLatDis, mLatCur, mPixDis, mPixCur;

	logic [15:0] lfsr = 16'd15;
	bit checkOn, palReady;
	int settle, errors, testErrors, failedTests, testsRun, watch, limit, curSeen;

	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);  // galois taps 16,14,13,11
	endfunction

	function automatic logic [7:0] randBits(int n);
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// framestore contents, a hash of address and scan row
	function automatic logic [7:0] frameByte(logic [`FSADR_W-1:0] adr, logic [`ROW_W-1:0] row);
		logic [15:0] s;
		logic [7:0] b;
		s = 16'd15 ^ {adr, 2'b00} ^ {11'd0, row};
		if (s == 16'd0) s = 16'd15;
		for (int i = 0; i < 8; i++) begin
			s = lfsrStep(s);
			b = {b[6:0], s[0]};
		end
		return b;
	endfunction

	function automatic logic [`FSADR_W-1:0] expAdr();
		return mRegs.startAdr + `FSADR_W'(mV) * `FSADR_W'(mRegs.hDisp) + `FSADR_W'(mH);
	endfunction

	function automatic bit expDisEn();
		return (mH < mRegs.hDisp) && (mV < mRegs.vDisp);
	endfunction

	// high from the sync column for as many characters as the low nibble says
	function automatic bit expHsync();
		int pos;
		pos = mRegs.hSyncPos;
		return (int'(mH) >= pos) && (int'(mH) < pos + int'(mRegs.syncWidth[3:0]));
	endfunction

	function automatic ulaPkg::rgb_t expRgb();
		ulaPkg::palEntry_t e;
		ulaPkg::rgb_t c;
		e = mPal[{mShift[7], mShift[5], mShift[3], mShift[1]}];
		c = (e.flash && mCtrl.flashOn) ? e.colour : ~e.colour;
		if (!mPixDis) c = 3'b000;
		return mPixCur ? ~c : c;
	endfunction

	task automatic reportError(string msg);
		errors++;
		testErrors++;
		if (errors <= 20) $display("%s", msg);
	endtask

	task automatic checkRgb(ulaPkg::rgb_t got, ulaPkg::rgb_t exp);
		if (got !== exp) begin
			reportError($sformatf("Error rgb got %h expected %h at %0t", got, exp, $time));
		end
	endtask

	task automatic checkAdr(logic [`FSADR_W-1:0] got, logic [`FSADR_W-1:0] exp, string name);
		if (got !== exp) reportError($sformatf("Error %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkSync(bit got, bit exp, string name);
		if (got !== exp) reportError($sformatf("Error %s got %h expected %h", name, got, exp));
	endtask

	task automatic stepModel();
		bit charEn, shiftEn, cur, lineEnd, lastScan;
		logic [`CROW_W-1:0] nextV;
		charEn = mCtrl.fastChar ? (mDiv[2:0] == 3'd0) : (mDiv == 4'd0);
		case (mCtrl.pixRate)
			ulaPkg::rate2:  shiftEn = mDiv[2:0] == 3'd0;
			ulaPkg::rate4:  shiftEn = mDiv[1:0] == 2'd0;
			ulaPkg::rate8:  shiftEn = !mDiv[0];
			default:        shiftEn = 1'b1;
		endcase
		if (charEn) begin
			mShift  = mLatData;  // second stage takes the older character
			mPixDis = mLatDis;
			mPixCur = mLatCur;
			cur = expDisEn() && (expAdr() == mRegs.cursorAdr);
			mLatData = frameByte(expAdr(), mRow);
			mLatDis  = expDisEn() && !mRow[3];
			mLatCur  = (cur && mCtrl.cursorWide) || (mSeg[0] && mCtrl.cursorSeg1)
				|| ((mSeg[1] || mSeg[2]) && mCtrl.cursorSeg23);
			mSeg = cur ? 4'd1 : {1'b0, mSeg[1:0], 1'b0};
			lineEnd  = mH >= mRegs.hTotal;
			lastScan = mRow >= mRegs.maxScan;
			nextV = !lastScan ? mV : (mV >= mRegs.vTotal ? '0 : mV + 1'b1);
			if (lineEnd) begin
				mH = '0;
				mRow = lastScan ? '0 : mRow + 1'b1;
				mV = nextV;
				if (lastScan && nextV == mRegs.vSyncPos) mVLeft = mRegs.syncWidth[7:4];
				else if (mVLeft != 4'd0) mVLeft = mVLeft - 1'b1;
			end else begin
				mH = mH + 1'b1;
			end
		end else if (shiftEn) begin
			mShift = {mShift[6:0], 1'b1};
		end
		if (mPixCur && mPixDis) curSeen++;
		mDiv = mDiv + 1'b1;
	endtask

	// compare, then advance the model to the state after the next edge
	always @(negedge CLK) begin
		if (checkOn) begin
			checkAdr(frameStoreAdr, expAdr(), "frameStoreAdr");
			checkAdr(`FSADR_W'(rowAddress), `FSADR_W'(mRow), "rowAddress");
			checkSync(hsync, expHsync(), "hsync");
			checkSync(vsync, mVLeft != 4'd0, "vsync");
			checkSync(txtMode, mCtrl.txtMode, "txtMode");
			if (palReady && settle == 0) checkRgb(rgb, expRgb());
		end
		if (settle != 0) settle--;
		if (!nRESET) begin
			{mRegs, mCtrl, mIdx, mDiv, mVLeft, mSeg, mH, mRow, mV} = '0;
			{mLatDis, mLatCur, mPixDis, mPixCur} = '0;
		end else begin
			stepModel();
		end
	end

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		vData <= frameByte(frameStoreAdr, rowAddress);  // framestore answers one clock later
		watch++;
		if (watch > limit) begin
			$display("timeout, vsync did not arrive within %0d cycles", limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic writeReg(bit ula, bit adrBit, logic [7:0] d);
		@(posedge CLK);
		procEn <= 1'b1;
		nCsCrtc <= ula;
		nCsUla <= !ula;
		a0 <= adrBit;
		rnw <= 1'b0;
		pData <= d;
		@(posedge CLK);
		procEn <= 1'b0;
		nCsCrtc <= 1'b1;
		nCsUla <= 1'b1;
		rnw <= 1'b1;
		settle = 48;  // the framestore lags a changed address by a clock
		if (ula && !adrBit) mCtrl = ulaPkg::ulaCtrl_t'(d);
		else if (ula) mPal[d[7:4]] = ulaPkg::palEntry_t'(d[3:0]);
		else if (!adrBit) mIdx = d[3:0];
		else begin
			case (crtcPkg::crtcReg_t'(mIdx))
				crtcPkg::regHTotal:    mRegs.hTotal = d;
				crtcPkg::regHDisp:     mRegs.hDisp = d;
				crtcPkg::regHSyncPos:  mRegs.hSyncPos = d;
				crtcPkg::regSyncWidth: mRegs.syncWidth = d;
				crtcPkg::regVTotal:    mRegs.vTotal = d[`CROW_W-1:0];
				crtcPkg::regVDisp:     mRegs.vDisp = d[`CROW_W-1:0];
				crtcPkg::regVSyncPos:  mRegs.vSyncPos = d[`CROW_W-1:0];
				crtcPkg::regMaxScan:   mRegs.maxScan = d[`ROW_W-1:0];
				crtcPkg::regStartHi:   mRegs.startAdr[`FSADR_W-1:8] = d[5:0];
				crtcPkg::regStartLo:   mRegs.startAdr[7:0] = d;
				crtcPkg::regCursorHi:  mRegs.cursorAdr[`FSADR_W-1:8] = d[5:0];
				crtcPkg::regCursorLo:  mRegs.cursorAdr[7:0] = d;
				default: ;
			endcase
		end
	endtask

	task automatic writeCrtc(crtcPkg::crtcReg_t r, logic [7:0] d);
		writeReg(1'b0, 1'b0, 8'(r));
		writeReg(1'b0, 1'b1, d);
	endtask

	// one whole frame between two vsync starts
	task automatic runFrame();
		int frameChars;
		frameChars = (mRegs.hTotal + 1) * (mRegs.maxScan + 1) * (mRegs.vTotal + 1);
		limit = 2 * frameChars * (mCtrl.fastChar ? 8 : 16) + 2000;
		watch = 0;
		@(posedge vsync);
		@(posedge vsync);
		limit = 1000000;
	endtask

	task automatic endTest(string name);
		testsRun++;
		if (testErrors != 0) failedTests++;
		$display("test %0d %s: %s (%0d errors)", testsRun, name,
			testErrors == 0 ? "ok" : "wrong", testErrors);
		testErrors = 0;
	endtask

	initial begin
		{procEn, a0, pData} = '0;
		{nCsCrtc, nCsUla, rnw} = 3'b111;
		vData = '0;
		nRESET = 1'b0;
		limit = 1000000;
		repeat (16) @(posedge CLK);
		nRESET <= 1'b1;
		checkOn = 1'b1;
		@(negedge CLK);
		checkSync(hsync, 1'b0, "hsync");
		checkSync(vsync, 1'b0, "vsync");
		checkRgb(rgb, 3'b000);
		checkAdr(frameStoreAdr, '0, "frameStoreAdr");
		endTest("reset");

		writeCrtc(crtcPkg::regHTotal, 8'd15);
		writeCrtc(crtcPkg::regHDisp, 8'd10);
		writeCrtc(crtcPkg::regHSyncPos, 8'd12);
		writeCrtc(crtcPkg::regSyncWidth, 8'h23);  // 2 lines, 3 characters
		writeCrtc(crtcPkg::regVTotal, 8'd5);
		writeCrtc(crtcPkg::regVDisp, 8'd4);
		writeCrtc(crtcPkg::regVSyncPos, 8'd4);
		writeCrtc(crtcPkg::regMaxScan, 8'd9);     // rows 8 and 9 are gap lines
		writeCrtc(crtcPkg::regStartHi, 8'h01);
		writeCrtc(crtcPkg::regStartLo, 8'h40);
		writeCrtc(crtcPkg::regCursorHi, 8'h3f);   // off screen for now
		runFrame();
		endTest("sync and address, slow characters");

		writeReg(1'b1, 1'b0, 8'h10);
		runFrame();
		endTest("address, fast characters");

		for (int i = 0; i < `PAL_ENTRIES; i++) writeReg(1'b1, 1'b1, {4'(i), 4'(randBits(4))});
		palReady = 1'b1;
		for (int r = 0; r < 4; r++) begin
			writeReg(1'b1, 1'b0, {3'b000, 1'(randBits(1)), 2'(r), 2'(randBits(2))});
			runFrame();
			endTest($sformatf("pixels at rate %0d", r));
		end

		writeCrtc(crtcPkg::regCursorHi, 8'h01);
		writeCrtc(crtcPkg::regCursorLo, 8'h40 + 8'd13);  // row 1, column 3
		writeReg(1'b1, 1'b0, {3'(randBits(3)) | 3'b100, 5'(randBits(5))});
		curSeen = 0;
		runFrame();
		if (curSeen == 0) reportError("the cursor never reached the display");
		endTest("cursor");

		$display("tests %0d, failed %0d, errors %0d", testsRun, failedTests, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
